// File: flist.f
logic/muldiv_cfg_pkg.sv
logic/muldiv_op_pkg.sv
logic/muldiv_ctl_if.sv
logic/step_sequencer.sv
logic/mreg_shifter.sv
logic/accum_unit.sv
logic/muldiv_top.sv
sim/tb_muldiv.sv

// File: logic/accum_unit.sv
/*
 * Accumulator: operand register D, add/subtract datapath
 * and Q register with the restoring-divide hold condition
 */
`timescale 1ns/1ps

module accum_unit
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  data_t        b,
   output data_t        q_out,
   muldiv_ctl_if.acc    ctl
);

   data_t             d;          // Multiplicand or divisor
   data_t             q;          // Product high half or partial remainder
   data_t             q_next;
   logic [DATA_W:0]   add_sum;    // Carry plus Q
   logic [DATA_W:0]   shl_q;      // Q shifted left, dividend bit in
   logic [DATA_W+1:0] trial;      // Shifted remainder minus D
   logic              borrow;
   logic              keep_shift; // Divide with borrow, no subtract

   always_comb begin
      // Multiply: conditional add, carry kept for the right shift
      add_sum = {1'b0, q} + (ctl.m_lsb ? {1'b0, d} : {(DATA_W + 1){1'b0}});
      // Divide: bring down next dividend bit and try D
      shl_q   = {q, ctl.m_msb};
      trial   = {1'b0, shl_q} - {2'b00, d};
      borrow  = trial[DATA_W+1];
   end

   assign keep_shift = (ctl.op == OP_DIVU) && borrow;

   always_comb begin
      if (ctl.op == OP_MUL) begin
         q_next = add_sum[DATA_W:1];            // Carry enters at msb
      end else if (keep_shift) begin
         q_next = shl_q[DATA_W-1:0];            // Restore, keep shifted Q
      end else begin
         q_next = trial[DATA_W-1:0];            // Subtraction fits
      end
   end

   // Operand register, captured once per operation
   always_ff @(posedge clk) begin
      if (ctl.load) begin
         d <= b;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q <= '0;
      end else if (ctl.load) begin
         q <= '0;
      end else if (ctl.step) begin
         q <= q_next;
      end
   end

   assign ctl.q_lsb = add_sum[0];   // Bit dropped into M msb
   assign ctl.fit   = ~borrow;      // Quotient bit into M lsb
   assign q_out     = q;

   // Q only moves on load or step
   a_q_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ctl.load || ctl.step) |=> $stable(q_out)
   );

   // Partial remainder stays below a nonzero divisor
   a_rem_bound : assert property (
      @(posedge clk) disable iff (!rst_n)
      (ctl.step && ctl.op == OP_DIVU && d != '0) |=> (q < d)
   );

endmodule : accum_unit

// File: logic/mreg_shifter.sv
/*
 * Bidirectional M shift register
 * Holds multiplier or dividend, collects product low half or quotient
 */
`timescale 1ns/1ps

module mreg_shifter
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  data_t        a,
   output data_t        m_out,
   muldiv_ctl_if.mreg   ctl
);

   data_t m;
   data_t shr_m;   // Multiply direction
   data_t shl_m;   // Divide direction

   // Product bit from Q enters at the top
   assign shr_m = {ctl.q_lsb, m[DATA_W-1:1]};
   // Quotient bit enters at the bottom
   assign shl_m = {m[DATA_W-2:0], ctl.fit};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m <= '0;
      end else if (ctl.load) begin
         m <= a;                             // Multiplier or dividend
      end else if (ctl.step) begin
         if (ctl.op == OP_MUL) begin
            m <= shr_m;
         end else begin
            m <= shl_m;
         end
      end
   end

   assign ctl.m_lsb = m[0];          // Add enable for this step
   assign ctl.m_msb = m[DATA_W-1];   // Next dividend bit for Q
   assign m_out     = m;

   // Result must hold through the ack phase and back-pressure
   a_m_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ctl.load || ctl.step) |=> $stable(m_out)
   );

endmodule : mreg_shifter

// File: logic/muldiv_cfg_pkg.sv
/*
 * Datapath configuration for the iterative multiplier/divider
 * Operand width, step counter width and the word types built on them
 */
package muldiv_cfg_pkg;

   // Operand width, one bit per iteration step
   localparam int DATA_W = 8;

   // Counter must reach DATA_W
   localparam int STEP_W = $clog2(DATA_W + 1);

   // One operand, quotient, remainder or product half
   typedef logic [DATA_W-1:0] data_t;

   // Full product as {Q, M}
   typedef logic [2*DATA_W-1:0] dword_t;

   // Step counter value
   typedef logic [STEP_W-1:0] step_t;

endpackage : muldiv_cfg_pkg

// File: logic/muldiv_ctl_if.sv
/*
 * Control and bit-exchange bundle between sequencer,
 * M shift register and accumulator, with one modport per block
 */
`timescale 1ns/1ps

interface muldiv_ctl_if
   import muldiv_op_pkg::*;
   ();

   logic       load;    // Capture operands, clear Q
   logic       step;    // One iteration per cycle
   muldiv_op_e op;      // Latched opcode

   logic       m_lsb;   // Multiplier bit, add enable
   logic       m_msb;   // Dividend bit shifted into Q
   logic       q_lsb;   // Product bit dropped from Q into M
   logic       fit;     // Trial subtraction without borrow, quotient bit

   // Producer of control
   modport seq (
      output load, step, op
   );

   // Operand buffer and result collector
   modport mreg (
      input  load, step, op,
      input  q_lsb, fit,
      output m_lsb, m_msb
   );

   // Arithmetic
   modport acc (
      input  load, step, op,
      input  m_lsb, m_msb,
      output q_lsb, fit
   );

endinterface : muldiv_ctl_if

// File: logic/muldiv_op_pkg.sv
/*
 * Opcode and sequencer state encodings
 */
package muldiv_op_pkg;

   // Operation select, held by the requester for the whole transaction
   typedef enum logic {
      OP_MUL  = 1'b0,   // Unsigned shift-and-add multiply
      OP_DIVU = 1'b1    // Unsigned restoring divide
   } muldiv_op_e;

   // Step sequencer states
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,   // Waiting for req
      ST_RUN  = 2'd1,   // DATA_W iteration steps
      ST_DONE = 2'd2    // Result valid, ack handshake
   } seq_state_e;

endpackage : muldiv_op_pkg

// File: logic/muldiv_top.sv
/*
 * Multiplier/divider top: handshake ports, control bundle
 * and the sequencer, M register and accumulator instances
 */
`timescale 1ns/1ps

module muldiv_top
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         req,         // Four-phase request
   input  muldiv_op_e   op,
   input  data_t        a,           // Multiplier or dividend
   input  data_t        b,           // Multiplicand or divisor
   output logic         ack,         // Result valid while high
   output data_t        result_hi,   // Product high or remainder
   output data_t        result_lo    // Product low or quotient
);

   data_t q_out;
   data_t m_out;

   muldiv_ctl_if ctl_i ();

   // Control producer
   step_sequencer step_sequencer_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .op    (op),
      .ack   (ack),
      .ctl   (ctl_i.seq)
   );

   // Operand a in, low result word out
   mreg_shifter mreg_shifter_i (
      .clk   (clk),
      .rst_n (rst_n),
      .a     (a),
      .m_out (m_out),
      .ctl   (ctl_i.mreg)
   );

   // Operand b in, high result word out
   accum_unit accum_unit_i (
      .clk   (clk),
      .rst_n (rst_n),
      .b     (b),
      .q_out (q_out),
      .ctl   (ctl_i.acc)
   );

   assign result_hi = q_out;
   assign result_lo = m_out;

endmodule : muldiv_top

// File: logic/step_sequencer.sv
/*
 * Step sequencer with four-phase req/ack handshake, opcode latch,
 * step counter and load/step strobes for the datapath
 */
`timescale 1ns/1ps

module step_sequencer
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         req,
   input  muldiv_op_e   op,
   output logic         ack,
   muldiv_ctl_if.seq    ctl
);

   localparam step_t LAST_STEP = step_t'(DATA_W - 1);  // Final iteration index

   seq_state_e state;
   step_t      step_cnt;   // Steps already done
   muldiv_op_e op_q;       // Opcode for the running operation
   logic       load_c;
   logic       step_c;

   // Load is seen in the cycle before the load edge
   assign load_c = (state == ST_IDLE) && req;
   assign step_c = (state == ST_RUN);

   assign ctl.load = load_c;
   assign ctl.step = step_c;
   assign ctl.op   = op_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         step_cnt <= '0;
         op_q     <= OP_MUL;
         ack      <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               ack <= 1'b0;
               if (req) begin              // Load edge
                  state    <= ST_RUN;
                  step_cnt <= '0;
                  op_q     <= op;
               end
            end
            ST_RUN: begin
               step_cnt <= step_cnt + step_t'(1);
               if (step_cnt == LAST_STEP) begin
                  state <= ST_DONE;         // Last step edge
               end
            end
            ST_DONE: begin
               // Ack follows req and the result holds until req drops
               ack <= req;
               if (!req) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
               ack   <= 1'b0;
            end
         endcase
      end
   end

   // No ack while the datapath is still iterating
   a_no_ack_in_run : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == ST_RUN) |-> !ack
   );

   // Operand capture never overlaps an iteration step
   a_load_step_excl : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(load_c && step_c)
   );

   // Ack comes exactly DATA_W+1 edges after the load edge while req holds
   a_ack_latency : assert property (
      @(posedge clk) disable iff (!rst_n)
      load_c ##1 (req [*(DATA_W + 1)]) |=> ack
   );

endmodule : step_sequencer

// File: run_sim.sh
#!/bin/sh
# Build the multiplier/divider testbench with Verilator, run it,
# and decide pass or fail from the simulation log

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --assert -j 0 --top-module tb_muldiv -f flist.f -o sim_muldiv \
   > "$BUILD_LOG" 2>&1 \
   || { echo "Verilator build failed, see $BUILD_LOG"; exit 1; }

./obj_dir/sim_muldiv > "$SIM_LOG" 2>&1 \
   || echo "Simulator returned a nonzero status"

grep -q "^RESULT: PASS$" "$SIM_LOG" \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed, see $SIM_LOG"; exit 1; }

// File: sim/muldiv_patterns.txt
// Columns, all hex: op (0 multiply, 1 divide), a, b, expected result_hi, expected result_lo
// Multiply gives {hi, lo} = a*b, divide gives hi = remainder and lo = quotient
// Multiply, zero and one
0 00 00 00 00
0 01 01 00 01
0 00 ff 00 00
0 ff 00 00 00
0 01 ff 00 ff
0 ff 01 00 ff
// Multiply, largest operands and carries
0 ff ff fe 01
0 fe fe fc 04
0 80 80 40 00
0 7f 81 3f ff
// Multiply, mixed values
0 0c 0a 00 78
0 10 10 01 00
0 80 02 01 00
0 a5 5a 3a 02
0 0f f0 0e 10
0 03 55 00 ff
0 2b 37 09 3d
// Divide, general
1 64 0a 00 0a
1 ff 01 00 ff
1 ff 10 0f 0f
1 80 03 02 2a
1 c8 07 04 1c
1 9b 0d 0c 0b
1 ff 02 01 7f
1 81 80 01 01
// Divide, a equal to b
1 ff ff 00 01
1 05 05 00 01
// Divide, a below b
1 03 07 03 00
1 00 05 00 00
1 fe ff fe 00
1 01 02 01 00
1 7f 80 7f 00
// Divide by zero, quotient all ones and remainder a
1 00 00 00 ff
1 01 00 01 ff
1 a5 00 a5 ff
1 ff 00 ff ff

// File: sim/tb_muldiv.sv
/*
 * Testbench for the iterative multiplier/divider
 * Clock, reset, four-phase driver, pattern reader, random mix,
 * compare tasks and cycle budget
 */
`timescale 1ns/1ps

module tb_muldiv
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;
();

   localparam int    N_RANDOM     = 200;   // Random ops after the directed set
   localparam int    MAX_HOLD     = 7;     // Extra req cycles after ack
   localparam int    RESET_CYCLES = 8;
   localparam int    MARGIN       = 50;
   localparam int    SEED         = 32'hf3c4_d4af;
   localparam string PATTERN_FILE = "sim/muldiv_patterns.txt";

   logic       clk;
   logic       rst_n;
   logic       req;
   muldiv_op_e op;
   data_t      a;
   data_t      b;
   logic       ack;
   data_t      result_hi;
   data_t      result_lo;

   // Directed operations from the pattern file
   muldiv_op_e pat_op[$];
   data_t      pat_a[$];
   data_t      pat_b[$];
   data_t      pat_hi[$];   // Product high or remainder
   data_t      pat_lo[$];   // Product low or quotient

   int cycle_count;
   int timeout_limit;
   int op_count;

   muldiv_top muldiv_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .op        (op),
      .a         (a),
      .b         (b),
      .ack       (ack),
      .result_hi (result_hi),
      .result_lo (result_lo)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   // Cycle budget with the limit set once the pattern count is known
   always @(posedge clk) begin
      cycle_count++;
      if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
         stop_run($sformatf("Timeout after %0d cycles, %0d operations done, DUT stuck",
                            cycle_count, op_count));
      end
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_product(input string name, input dword_t expected, input dword_t actual);
      if (actual !== expected) begin
         stop_run($sformatf("FAIL t=%0t %s expected %h actual %h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic check_word(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         stop_run($sformatf("FAIL t=%0t %s expected %h actual %h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic check_latency(input string name, input int expected, input int actual);
      if (actual != expected) begin
         stop_run($sformatf("FAIL t=%0t %s expected %0d actual %0d",
                            $time, name, expected, actual));
      end
   endtask

   // Reference arithmetic returning {hi, lo}
   function automatic dword_t model_result(input muldiv_op_e o, input data_t x, input data_t y);
      dword_t r;
      if (o == OP_MUL) begin
         r = dword_t'(x) * dword_t'(y);
      end else if (y == '0) begin
         r = {x, {DATA_W{1'b1}}};              // Quotient all ones and remainder a
      end else begin
         r = {data_t'(x % y), data_t'(x / y)};
      end
      return r;
   endfunction

   task automatic read_patterns();
      int          fd;
      string       line;
      logic [31:0] f_op;
      logic [31:0] f_a;
      logic [31:0] f_b;
      logic [31:0] f_hi;
      logic [31:0] f_lo;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         stop_run("Could not open the pattern file sim/muldiv_patterns.txt");
      end
      while ($fgets(line, fd) != 0) begin
         // Comment and blank lines do not scan as five fields
         if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_hi, f_lo) == 5) begin
            pat_op.push_back(f_op[0] ? OP_DIVU : OP_MUL);
            pat_a.push_back(f_a[DATA_W-1:0]);
            pat_b.push_back(f_b[DATA_W-1:0]);
            pat_hi.push_back(f_hi[DATA_W-1:0]);
            pat_lo.push_back(f_lo[DATA_W-1:0]);
         end
      end
      $fclose(fd);
      if (pat_op.size() == 0) begin
         stop_run("Pattern file holds no operations");
      end
   endtask

   // One four-phase transaction entered and left on a falling edge
   task automatic do_transaction(input muldiv_op_e o, input data_t x, input data_t y,
                                 input data_t exp_hi, input data_t exp_lo);
      int    lat;
      int    hold;
      op  = o;
      a   = x;
      b   = y;
      req = 1'b1;
      @(posedge clk);                            // Load edge
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
         @(negedge clk);                         // Sample away from the edge
      end while (ack !== 1'b1);
      check_latency("ack latency", DATA_W + 1, lat);
      if (o == OP_MUL) begin
         check_product("{result_hi, result_lo}", {exp_hi, exp_lo}, {result_hi, result_lo});
      end else begin
         check_word("result_lo", exp_lo, result_lo);   // Quotient
         check_word("result_hi", exp_hi, result_hi);   // Remainder
      end
      hold = int'($urandom_range(MAX_HOLD, 0));
      // Back-pressure keeps everything frozen while req stays high
      repeat (hold) begin
         @(negedge clk);
         if (ack !== 1'b1) begin
            stop_run("ack dropped while req was still held high");
         end
         check_word("result_hi", exp_hi, result_hi);
         check_word("result_lo", exp_lo, result_lo);
      end
      req = 1'b0;
      @(negedge clk);
      if (ack !== 1'b0) begin
         stop_run("ack still high one edge after req was sampled low");
      end
      op_count++;
   endtask

   initial begin
      dword_t     expected;
      muldiv_op_e r_op;
      data_t      r_a;
      data_t      r_b;
      rst_n         = 1'b0;
      req           = 1'b0;
      op            = OP_MUL;
      a             = '0;
      b             = '0;
      cycle_count   = 0;
      op_count      = 0;
      timeout_limit = 0;
      void'($urandom(SEED));
      read_patterns();
      timeout_limit = (pat_op.size() + N_RANDOM) * (DATA_W + 2 + MAX_HOLD + 4)
                      + RESET_CYCLES + MARGIN;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      if (ack !== 1'b0) begin
         stop_run("ack not low after reset");
      end
      // Directed set
      foreach (pat_op[i]) begin
         do_transaction(pat_op[i], pat_a[i], pat_b[i], pat_hi[i], pat_lo[i]);
      end
      // Random mix with some zero divisors
      repeat (N_RANDOM) begin
         r_op = ($urandom_range(1, 0) == 1) ? OP_DIVU : OP_MUL;
         r_a  = data_t'($urandom_range(255, 0));
         r_b  = data_t'($urandom_range(255, 0));
         if ($urandom_range(15, 0) == 0) begin
            r_b = '0;
         end
         expected = model_result(r_op, r_a, r_b);
         do_transaction(r_op, r_a, r_b, expected[2*DATA_W-1:DATA_W], expected[DATA_W-1:0]);
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule : tb_muldiv
